// ==== board_top.f ====
logic/board_pkg.sv
logic/slow_clk_gen.sv
logic/i2s_mic_receiver.sv
logic/seven_seg_scanner.sv
logic/lab_top.sv
logic/board_top.sv
verification/board_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the board_top testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the simulation stops on $fatal.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module board_top_tb \
    --Mdir obj_dir -o board_top_sim \
    -f board_top.f
then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/board_top_sim
status=$?
if [ "$status" -ne 0 ]
then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== verification/board_top_tb.sv ====
`default_nettype none

module board_top_tb;

    import board_pkg::*;

    localparam clk_period    = 100;
    localparam clk_mhz       = 1;
    localparam slow_clk_hz   = 100000;
    localparam sck_div       = 2;
    localparam scan_div      = 3;
    localparam strobe_period = clk_mhz * 1000000 / slow_clk_hz;   // 10 cycles
    localparam frame_cycles  = 64 * 2 * sck_div;                  // One I2S frame
    localparam scan_cycles   = 4 * scan_div + 2;                  // Full display refresh
    localparam n_strobes     = 5;
    localparam n_frames      = 2;
    localparam timeout_cycles = 100 + strobe_period * (n_strobes + 3)
                                + frame_cycles * (n_frames + 3) + 4 * scan_cycles;

    logic        clk = 1'b0;
    logic        rst;
    logic [3:0]  key_n;
    logic [8:0]  sw;
    logic [9:0]  ledr;
    logic [7:0]  ledg;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [6:0]  hex2;
    logic [6:0]  hex3;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        mic_sd = 1'b0;

    int          active_edges = 0;             // Clock edges seen out of reset
    logic [5:0]  mic_pos = '0;                 // Model copy of the sck period index
    logic [23:0] mic_word = '0;
    logic [4:0]  bit_idx;
    logic [23:0] sent_q[$];                    // Every word put on sd

    always #(clk_period / 2) clk = ~clk;

    board_top
    #(
        .clk_mhz     (clk_mhz),
        .slow_clk_hz (slow_clk_hz),
        .sck_div     (sck_div),
        .scan_div    (scan_div),
        .w_key       (4),
        .w_sw        (9)
    )
    u_board_top
    (
        .clk     (clk),
        .rst     (rst),
        .key_n   (key_n),
        .sw      (sw),
        .ledr    (ledr),
        .ledg    (ledg),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3),
        .mic_sck (mic_sck),
        .mic_ws  (mic_ws),
        .mic_lr  (mic_lr),
        .mic_sd  (mic_sd)
    );

    always @(posedge clk)
    begin
        if (rst)
            active_edges <= 0;
        else
            active_edges <= active_edges + 1;  // Strobe lands on every 10th edge
    end

    //------------------------------------------------------------
    // Microphone model, left slot MSB first after one bit delay

    always @(negedge mic_sck)
    begin
        if (!rst)
        begin
            mic_pos = mic_pos + 6'd1;
            if (mic_pos == 6'd1)               // Fresh word for each left slot
            begin
                mic_word = 24'($urandom);
                sent_q.push_back(mic_word);
            end
            bit_idx = 5'(6'd24 - mic_pos);
            if (mic_pos >= 6'd1 && mic_pos <= 6'd24)
                mic_sd <= mic_word[bit_idx];
            else
                mic_sd <= 1'b0;                // Idle and right slot
        end
    end

    //------------------------------------------------------------
    // Checking helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        begin
            if (actual !== expected)
            begin
                $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
                $display("Regression failed");
                $fatal(1, "Stopped at the first mismatch");
            end
        end
    endtask

    function automatic logic [13:0] expected_led(input int count);
        return 14'(count) ^ {5'b0, sw};        // Switches XOR onto low LEDs
    endfunction

    function automatic logic [6:0] hex_expected(input logic [3:0] nibble);
        return ~seg_of_hex(nibble);            // Board digits are active low
    endfunction

    task automatic check_digits(input logic [15:0] value);
        begin
            check_value("hex0", 32'(hex_expected(value[3:0])), 32'(hex0));
            check_value("hex1", 32'(hex_expected(value[7:4])), 32'(hex1));
            check_value("hex2", 32'(hex_expected(value[11:8])), 32'(hex2));
            check_value("hex3", 32'(hex_expected(value[15:12])), 32'(hex3));
        end
    endtask

    task automatic check_leds(input int count);
        logic [13:0] led_exp;
        begin
            led_exp = expected_led(count);
            check_value("ledg", 32'(led_exp[7:0]), 32'(ledg));
            check_value("ledr[5:0]", 32'(led_exp[13:8]), 32'(ledr[5:0]));
        end
    endtask

    //------------------------------------------------------------
    // Directed tests

    task automatic check_reset_values;
        begin
            @(negedge clk);                    // No active edge yet
            check_value("hex0", 32'h7f, 32'(hex0));
            check_value("hex1", 32'h7f, 32'(hex1));
            check_value("hex2", 32'h7f, 32'(hex2));
            check_value("hex3", 32'h7f, 32'(hex3));
            check_value("ledr[9:6]", 32'd0, 32'(ledr[9:6]));
            check_leds(0);
            check_value("mic_sck", 32'd0, 32'(mic_sck));
            check_value("mic_ws", 32'd0, 32'(mic_ws));
            check_value("mic_lr", 32'd0, 32'(mic_lr));
        end
    endtask

    task automatic check_slow_counter;
        int release_edge;
        int last_strobe;
        begin
            repeat (2 * strobe_period) @(posedge clk);  // Counter leaves zero first
            @(posedge clk);
            key_n[0] <= 1'b0;                  // Press clear
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_leds(0);
            @(posedge clk);
            key_n[0] <= 1'b1;
            release_edge = active_edges + 1;   // Clear still seen on this edge
            last_strobe  = (release_edge / strobe_period + 1) * strobe_period
                           + (n_strobes - 1) * strobe_period;
            while (active_edges < last_strobe)
                @(negedge clk);
            check_leds(n_strobes);
            @(posedge clk);
            key_n[0] <= 1'b0;                  // Clear again
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_leds(0);
            @(posedge clk);
            key_n[0] <= 1'b1;
        end
    endtask

    task automatic check_mic_capture;
        logic [23:0] word;
        begin
            @(posedge clk);
            sw[0] <= 1'b1;                     // Show the microphone word
            repeat (n_frames)
            begin
                @(posedge mic_ws);             // Left slot over and word latched
                if (sent_q.size() == 0)
                begin
                    $display("The microphone model sent no word before a left slot ended");
                    $display("Regression failed");
                    $fatal(1, "No microphone word to compare");
                end
                else
                begin
                    word = sent_q[$];
                    repeat (scan_cycles) @(posedge clk);
                    @(negedge clk);
                    check_digits(word[23:8]);
                    check_value("ledr[6]", 32'(word[23]), 32'(ledr[6]));
                    check_value("ledr[9:7]", 32'd0, 32'(ledr[9:7]));
                end
            end
        end
    endtask

    task automatic check_counter_display;
        int frozen;
        begin
            frozen = 0;                        // Clear pins the counter here
            @(posedge clk);
            sw[0]    <= 1'b0;
            key_n[0] <= 1'b0;
            repeat (scan_cycles) @(posedge clk);
            @(negedge clk);
            check_digits(16'(frozen));
            check_value("ledr[9:6]", 32'd0, 32'(ledr[9:6]));
            check_leds(frozen);
            @(posedge clk);
            key_n[0] <= 1'b1;
        end
    endtask

    task automatic check_i2s_timing;
        int   sck_run;
        int   ws_run;
        int   sck_edges;
        int   ws_edges;
        logic sck_prev;
        logic ws_prev;
        begin
            sck_run   = 0;
            ws_run    = 0;
            sck_edges = 0;
            ws_edges  = 0;
            @(negedge clk);
            sck_prev = mic_sck;
            ws_prev  = mic_ws;
            while (ws_edges < 3)               // Two whole ws levels measured
            begin
                @(negedge clk);
                sck_run++;
                ws_run++;
                if (mic_sck != sck_prev)
                begin
                    if (sck_edges > 0)         // First run is partial
                        check_value("mic_sck half period", 32'(sck_div), 32'(sck_run));
                    sck_edges++;
                    sck_run = 0;
                end
                if (mic_ws != ws_prev)
                begin
                    check_value("mic_sck at mic_ws change", 32'd0, 32'(mic_sck));
                    if (ws_edges > 0)
                        check_value("mic_ws level cycles", 32'(32 * 2 * sck_div),
                                    32'(ws_run));
                    ws_edges++;
                    ws_run = 0;
                end
                sck_prev = mic_sck;
                ws_prev  = mic_ws;
            end
        end
    endtask

    //------------------------------------------------------------
    // Test sequence and watchdog

    initial
    begin
        void'($urandom(66));
        rst   = 1'b1;
        key_n = '1;                            // No key pressed
        sw    = 9'h1a6;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        check_reset_values();
        check_slow_counter();
        check_mic_capture();
        check_counter_display();
        check_i2s_timing();
        $display("Regression passed");
        $finish;
    end

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("Watchdog expired after %0d clock cycles before the tests finished",
                 timeout_cycles);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== logic/board_top.sv ====
`default_nettype none

module board_top
#(
    parameter clk_mhz     = 50,
    parameter slow_clk_hz = 1,
    parameter sck_div     = 8,
    parameter scan_div    = 50000,
    parameter w_key       = 4,
    parameter w_sw        = 9
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [w_key - 1:0] key_n,          // Pressed is low
    input  logic [w_sw - 1:0]  sw,
    output logic [9:0]         ledr,           // Top four act as decimal points
    output logic [7:0]         ledg,
    output logic [6:0]         hex0,           // Active low, no dp pin
    output logic [6:0]         hex1,
    output logic [6:0]         hex2,
    output logic [6:0]         hex3,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,
    input  logic               mic_sd
);

    import board_pkg::*;

    logic [w_key - 1:0]          key;
    logic                        slow_strobe;
    mic_sample_t                 sample;
    logic                        sample_valid;
    logic [13:0]                 led;
    seg_frame_t                  frame;
    logic [n_digits - 1:0][6:0]  hex_q;        // Sticky digit latches
    logic [n_digits - 1:0]       dp_q;

    assign key = ~key_n;

    //------------------------------------------------------------
    // Submodules

    slow_clk_gen #(.fast_clk_mhz (clk_mhz), .slow_clk_hz (slow_clk_hz))
    i_slow_clk_gen (.clk (clk), .rst (rst), .slow_strobe (slow_strobe));

    i2s_mic_receiver #(.sck_div (sck_div))
    i_microphone
    (
        .clk          (clk),
        .rst          (rst),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .sd           (mic_sd),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    lab_top #(.w_key (w_key), .w_sw (w_sw), .scan_div (scan_div))
    i_lab_top
    (
        .clk          (clk),
        .rst          (rst),
        .slow_strobe  (slow_strobe),
        .key          (key),
        .sw           (sw),
        .sample       (sample),
        .sample_valid (sample_valid),
        .led          (led),
        .frame        (frame)
    );

    //------------------------------------------------------------
    // Static digits emulating the dynamic display

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex_q <= '1;                       // All segments dark
            dp_q  <= '0;
        end
        else
            for (int i = 0; i < n_digits; i++)
                if (frame.digit[i])            // Hold while not selected
                begin
                    hex_q[i] <= ~frame.abcdefgh[7:1];
                    dp_q[i]  <= frame.abcdefgh[0];
                end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

    assign ledg   = led[7:0];
    assign ledr   = {dp_q, led[13:8]};         // Decimal points on ledr 9..6
    assign mic_lr = 1'b0;                      // Left channel select

endmodule

`default_nettype wire

// ==== logic/lab_top.sv ====
`default_nettype none

module lab_top
#(
    parameter w_key    = 4,
    parameter w_sw     = 9,
    parameter scan_div = 50000
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   slow_strobe,
    input  logic [w_key - 1:0]     key,
    input  logic [w_sw - 1:0]      sw,
    input  board_pkg::mic_sample_t sample,
    input  logic                   sample_valid,
    output logic [13:0]            led,
    output board_pkg::seg_frame_t  frame
);

    import board_pkg::*;

    localparam w_cnt  = 14;                    // Matches the LED vector
    localparam w_disp = 4 * n_digits;          // Hex digits on display

    logic [w_cnt - 1:0]    cnt;                // Slow counter
    mic_sample_t           sample_q;           // Latest microphone word
    logic [w_disp - 1:0]   disp_value;
    logic [n_digits - 1:0] disp_dp;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (key[0])                       // Clear wins over count
            cnt <= '0;
        else if (slow_strobe)
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample_q <= '0;
        else if (sample_valid)
            sample_q <= sample;
    end

    assign led        = cnt ^ w_cnt'(sw[8:0]);
    assign disp_value = sw[0] ? sample_q[w_sample - 1 -: w_disp] : w_disp'(cnt);
    assign disp_dp    = n_digits'(sw[0] & sample_q[w_sample - 1]);  // Sign on dp 0

    seven_seg_scanner
    #(
        .scan_div (scan_div)
    )
    i_scanner
    (
        .clk   (clk),
        .rst   (rst),
        .value (disp_value),
        .dp    (disp_dp),
        .frame (frame)
    );

endmodule

`default_nettype wire

// ==== logic/seven_seg_scanner.sv ====
`default_nettype none

module seven_seg_scanner
#(
    parameter scan_div = 50000
)
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [4 * board_pkg::n_digits - 1:0] value,
    input  logic [board_pkg::n_digits - 1:0]     dp,
    output board_pkg::seg_frame_t               frame
);

    import board_pkg::*;

    localparam w_div = scan_div > 1 ? $clog2(scan_div) : 1;

    logic [w_div - 1:0]    div_cnt;            // Cycles spent on current digit
    logic [n_digits - 1:0] sel;                // One-hot active digit
    logic [3:0]            nibble;
    logic                  dp_bit;

    //------------------------------------------------------------
    // Digit rotation

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sel     <= n_digits'(1);           // Start on digit 0
        end
        else if (div_cnt == w_div'(scan_div - 1))
        begin
            div_cnt <= '0;
            sel     <= {sel[n_digits - 2:0], sel[n_digits - 1]};
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // Nibble and dp of the selected digit
    always_comb
    begin
        nibble = '0;
        dp_bit = 1'b0;
        for (int i = 0; i < n_digits; i++)
            if (sel[i])
            begin
                nibble = value[4 * i +: 4];
                dp_bit = dp[i];
            end
    end

    //------------------------------------------------------------
    // Registered frame, segments always match digit

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame.digit    <= n_digits'(1);
            frame.abcdefgh <= {seg_of_hex(4'h0), 1'b0};
        end
        else
        begin
            frame.digit    <= sel;
            frame.abcdefgh <= {seg_of_hex(nibble), dp_bit};
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot(frame.digit));

endmodule

`default_nettype wire

// ==== logic/i2s_mic_receiver.sv ====
`default_nettype none

module i2s_mic_receiver
#(
    parameter sck_div = 8
)
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   sck,
    output logic                   ws,
    input  logic                   sd,
    output board_pkg::mic_sample_t sample,
    output logic                   sample_valid
);

    import board_pkg::*;

    localparam w_div    = sck_div > 1 ? $clog2(sck_div) : 1;
    localparam last_bit = w_sample;            // bit_cnt of the LSB in the left slot

    logic [w_div - 1:0]    div_cnt;            // Half period counter
    logic                  sck_edge;
    logic                  sck_rise;
    logic                  sck_fall;
    logic [5:0]            bit_cnt;            // sck periods within one frame
    i2s_slot_e             slot;
    logic [w_sample - 1:0] shift_q;            // Incoming word, MSB first
    logic                  shift_en;
    logic                  capture;

    //------------------------------------------------------------
    // Serial clock

    assign sck_edge = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise = sck_edge & ~sck;         // sck goes high at this clk edge
    assign sck_fall = sck_edge &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;                   // Idle low
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    //------------------------------------------------------------
    // Word select and slot tracking

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt <= '0;
            slot    <= left_slot;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt[4:0] == 5'd31)         // Every 32 sck periods
                slot <= (slot == left_slot) ? right_slot : left_slot;
        end
    end

    assign ws = (slot == right_slot);

    //------------------------------------------------------------
    // Data capture, one bit delay after ws falls

    assign shift_en = sck_rise && slot == left_slot
                      && bit_cnt >= 6'd1 && bit_cnt <= 6'(last_bit);
    assign capture  = sck_fall && slot == left_slot && bit_cnt == 6'(last_bit);

    always_ff @(posedge clk)
    begin
        if (shift_en)
            shift_q <= {shift_q[w_sample - 2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= capture;           // Single clk pulse
            if (capture)
                sample <= shift_q;
        end
    end

    // Only the left channel is ever presented
    assert property (@(posedge clk) disable iff (rst) sample_valid |-> slot == left_slot);

endmodule

`default_nettype wire

// ==== logic/slow_clk_gen.sv ====
`default_nettype none

module slow_clk_gen
#(
    parameter fast_clk_mhz = 50,
    parameter slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_strobe
);

    localparam period = fast_clk_mhz * 1000000 / slow_clk_hz;  // clk cycles per strobe
    localparam w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;                   // Cycles left until next strobe

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= w_cnt'(period - 1);
        else if (cnt == '0)
            cnt <= w_cnt'(period - 1);         // Reload at terminal count
        else
            cnt <= cnt - 1'b1;
    end

    assign slow_strobe = (cnt == '0);          // One cycle wide enable

    // A strobe is never followed directly by another one
    assert property (@(posedge clk) disable iff (rst) slow_strobe |=> !slow_strobe);

endmodule

`default_nettype wire

// ==== logic/board_pkg.sv ====
`default_nettype none

package board_pkg;

    //------------------------------------------------------------
    // Board and microphone constants

    localparam n_digits = 4;                   // Static digits on the board
    localparam w_sample = 24;                  // I2S microphone word length

    typedef logic signed [w_sample - 1:0] mic_sample_t;

    //------------------------------------------------------------
    // Dynamic display frame, one digit at a time

    typedef struct packed
    {
        logic [7:0]            abcdefgh;       // Segments a..g in 7..1, dp in 0
        logic [n_digits - 1:0] digit;          // One-hot digit select
    } seg_frame_t;

    typedef enum logic
    {
        left_slot,                             // ws low
        right_slot                             // ws high
    } i2s_slot_e;

    //------------------------------------------------------------

    // Hex font, active-high a..g in bits 6..0
    function automatic logic [6:0] seg_of_hex(input logic [3:0] hex);
        case (hex)
            4'h0:    return 7'b1111110;
            4'h1:    return 7'b0110000;
            4'h2:    return 7'b1101101;
            4'h3:    return 7'b1111001;
            4'h4:    return 7'b0110011;
            4'h5:    return 7'b1011011;
            4'h6:    return 7'b1011111;
            4'h7:    return 7'b1110000;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1111011;
            4'ha:    return 7'b1110111;
            4'hb:    return 7'b0011111;            // Lower case b
            4'hc:    return 7'b1001110;
            4'hd:    return 7'b0111101;            // Lower case d
            4'he:    return 7'b1001111;
            default: return 7'b1000111;            // F
        endcase
    endfunction

endpackage

`default_nettype wire
